// File: Makefile
# Verilator build and run of the AES control unit testbench

BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_cipher_ctrl with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_cipher_ctrl \
		-f verilog.f -Mdir $(BUILD) -o sim_tb
	./$(BUILD)/sim_tb

clean:
	rm -rf $(BUILD)

// File: hdl/aes_ctrl_pkg.sv
// AES control unit definitions; enum encodings are sparse or one-hot and must match the datapath

package aes_ctrl_pkg;

  ////////////////////////////////////////////////////
  // Round counting
  ////////////////////////////////////////////////////

  // Round counter width, enough for 14 rounds
  localparam int unsigned RndCtrW = 4;

  // Number of rounds per key length
  localparam logic [RndCtrW-1:0] NumRounds128 = 4'd10;
  localparam logic [RndCtrW-1:0] NumRounds192 = 4'd12;
  localparam logic [RndCtrW-1:0] NumRounds256 = 4'd14;

  ////////////////////////////////////////////////////
  // Command encodings
  ////////////////////////////////////////////////////

  // Cipher direction, sparse
  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  // Key length, one-hot
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  // Control FSM states, sparse so a single flip lands on an invalid code
  typedef enum logic [5:0] {
    CTRL_IDLE     = 6'b011101,
    CTRL_INIT     = 6'b110000,
    CTRL_ROUND    = 6'b001011,
    CTRL_FINISH   = 6'b100110,
    CTRL_CLEAR_S  = 6'b010010,
    CTRL_CLEAR_KD = 6'b101101,
    CTRL_ERROR    = 6'b111011
  } ctrl_state_e;

  // Phase reported to the selector decode
  typedef enum logic [2:0] {
    PHASE_OTHER  = 3'd0,
    PHASE_INIT   = 3'd1,
    PHASE_ROUND  = 3'd2,
    PHASE_FINISH = 3'd3,
    PHASE_CLEAR  = 3'd4
  } ctrl_phase_e;

  ////////////////////////////////////////////////////
  // Datapath mux selectors
  ////////////////////////////////////////////////////

  typedef enum logic [1:0] {STATE_ROUND, STATE_INIT, STATE_CLEAR} state_sel_e;
  typedef enum logic [1:0] {ADD_RK_INIT, ADD_RK_ROUND, ADD_RK_FINAL} add_rk_sel_e;
  typedef enum logic [1:0] {
    KEY_FULL_ROUND, KEY_FULL_ENC_INIT, KEY_FULL_DEC_INIT, KEY_FULL_CLEAR
  } key_full_sel_e;
  typedef enum logic {KEY_DEC_EXPAND, KEY_DEC_CLEAR} key_dec_sel_e;
  typedef enum logic [1:0] {
    KEY_WORDS_0123, KEY_WORDS_2345, KEY_WORDS_4567, KEY_WORDS_ZERO
  } key_words_sel_e;
  typedef enum logic {ROUND_KEY_DIRECT, ROUND_KEY_MIXED} round_key_sel_e;

endpackage

// File: hdl/cipher_cmd_regs.sv
// Command flag registers; start takes priority over done in the same cycle
`timescale 1ns/1ns

module cipher_cmd_regs (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic done_i,
  input  logic crypt_d_i,
  input  logic dec_key_gen_d_i,
  input  logic key_clear_d_i,
  input  logic data_out_clear_d_i,
  output logic crypt_q_o,
  output logic dec_key_gen_q_o,
  output logic key_clear_q_o,
  output logic data_out_clear_q_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crypt_q_o          <= 1'b0;
      dec_key_gen_q_o    <= 1'b0;
      key_clear_q_o      <= 1'b0;
      data_out_clear_q_o <= 1'b0;
    end else if (start_i) begin
      // Command accepted
      crypt_q_o          <= crypt_d_i;
      dec_key_gen_q_o    <= dec_key_gen_d_i;
      key_clear_q_o      <= key_clear_d_i;
      data_out_clear_q_o <= data_out_clear_d_i;
    end else if (done_i) begin
      // Result taken, nothing in flight
      crypt_q_o          <= 1'b0;
      dec_key_gen_q_o    <= 1'b0;
      key_clear_q_o      <= 1'b0;
      data_out_clear_q_o <= 1'b0;
    end
  end

endmodule

// File: hdl/cipher_ctrl_fsm.sv
// AES control FSM; error state is terminal and only reset leaves it
`timescale 1ns/1ns

module cipher_ctrl_fsm import aes_ctrl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  input  logic          in_valid_i,
  output logic          in_ready_o,
  output logic          out_valid_o,
  input  logic          out_ready_i,

  input  key_len_e      key_len_i,
  input  logic          crypt_i,
  input  logic          dec_key_gen_i,
  input  logic          key_clear_i,
  input  logic          data_out_clear_i,
  input  logic          sel_err_i,
  input  logic          alert_fatal_i,
  output logic          alert_o,

  output state_sel_e    state_sel_o,
  output logic          state_we_o,
  output logic          sub_bytes_en_o,
  input  logic          sub_bytes_out_req_i,
  output logic          sub_bytes_out_ack_o,
  output add_rk_sel_e   add_rk_sel_o,

  output key_full_sel_e key_full_sel_o,
  output logic          key_full_we_o,
  output key_dec_sel_e  key_dec_sel_o,
  output logic          key_dec_we_o,
  output logic          key_expand_en_o,
  input  logic          key_expand_out_req_i,
  output logic          key_expand_out_ack_o,
  output logic          key_expand_clear_o,

  // Sequencing towards the helpers
  output logic          start_o,
  output logic          done_o,
  input  logic          last_round_i,
  output logic          round_adv_o,
  output ctrl_phase_e   phase_o,
  input  key_full_sel_e key_full_init_i,

  // Command flags
  output logic          crypt_d_o,
  output logic          dec_key_gen_d_o,
  output logic          key_clear_d_o,
  output logic          data_out_clear_d_o,
  input  logic          crypt_q_i,
  input  logic          dec_key_gen_q_i,
  input  logic          key_clear_q_i,
  input  logic          data_out_clear_q_i
);

  ctrl_state_e state_d, state_q;
  logic        advance;

  always_comb begin
    // Safe defaults, no writes, no handshakes
    in_ready_o           = 1'b0;
    out_valid_o          = 1'b0;
    alert_o              = 1'b0;
    state_sel_o          = STATE_ROUND;
    state_we_o           = 1'b0;
    sub_bytes_en_o       = 1'b0;
    sub_bytes_out_ack_o  = 1'b0;
    add_rk_sel_o         = ADD_RK_ROUND;
    key_full_sel_o       = KEY_FULL_ROUND;
    key_full_we_o        = 1'b0;
    key_dec_sel_o        = KEY_DEC_EXPAND;
    key_dec_we_o         = 1'b0;
    key_expand_en_o      = 1'b0;
    key_expand_out_ack_o = 1'b0;
    key_expand_clear_o   = 1'b0;
    start_o              = 1'b0;
    done_o               = 1'b0;
    round_adv_o          = 1'b0;
    phase_o              = PHASE_OTHER;
    crypt_d_o            = 1'b0;
    dec_key_gen_d_o      = 1'b0;
    key_clear_d_o        = 1'b0;
    data_out_clear_d_o   = 1'b0;
    advance              = 1'b0;
    state_d              = state_q;

    unique case (state_q)
      CTRL_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          if (key_clear_i || data_out_clear_i) begin
            // Clears win over crypt, state is wiped first if data goes too
            start_o            = 1'b1;
            key_clear_d_o      = key_clear_i;
            data_out_clear_d_o = data_out_clear_i;
            state_d            = data_out_clear_i ? CTRL_CLEAR_S : CTRL_CLEAR_KD;
          end else if (crypt_i || dec_key_gen_i) begin
            start_o            = 1'b1;
            crypt_d_o          = crypt_i & ~dec_key_gen_i;
            dec_key_gen_d_o    = dec_key_gen_i;
            // Key generation runs on a cleared state
            state_sel_o        = dec_key_gen_i ? STATE_CLEAR : STATE_INIT;
            state_we_o         = 1'b1;
            key_expand_clear_o = 1'b1;
            key_full_sel_o     = dec_key_gen_i ? KEY_FULL_ENC_INIT : key_full_init_i;
            key_full_we_o      = 1'b1;
            state_d            = CTRL_INIT;
          end else begin
            // Handshake with no command bit set
            state_d = CTRL_ERROR;
          end
        end
      end

      CTRL_INIT: begin
        phase_o      = PHASE_INIT;
        add_rk_sel_o = ADD_RK_INIT;
        // AES-256 has both first round keys at hand, no key expand wait
        if (key_len_i != AES_256) begin
          key_expand_en_o = 1'b1;
          advance         = key_expand_out_req_i;
        end else begin
          advance = 1'b1;
        end
        if (advance) begin
          key_expand_out_ack_o = key_expand_en_o;
          key_full_we_o        = key_expand_en_o;
          state_we_o           = crypt_q_i;
          round_adv_o          = 1'b1;
          state_d              = CTRL_ROUND;
        end
      end

      CTRL_ROUND: begin
        phase_o         = PHASE_ROUND;
        sub_bytes_en_o  = crypt_q_i;
        key_expand_en_o = 1'b1;
        // Key generation skips SubBytes
        advance = key_expand_out_req_i & (~crypt_q_i | sub_bytes_out_req_i);
        if (advance) begin
          sub_bytes_out_ack_o  = crypt_q_i;
          key_expand_out_ack_o = 1'b1;
          state_we_o           = crypt_q_i;
          key_full_we_o        = 1'b1;
          round_adv_o          = 1'b1;
          if (last_round_i) begin
            state_d = CTRL_FINISH;
            if (dec_key_gen_q_i) begin
              // Last round key is the decryption start key
              key_dec_we_o = 1'b1;
              // Try to finish right here, else wait in finish
              out_valid_o  = ~sel_err_i;
              if (out_valid_o && out_ready_i) begin
                done_o  = 1'b1;
                state_d = CTRL_IDLE;
              end
            end
          end
        end
      end

      CTRL_FINISH: begin
        phase_o        = PHASE_FINISH;
        add_rk_sel_o   = ADD_RK_FINAL;
        // State gets wiped on the way out
        state_sel_o    = STATE_CLEAR;
        sub_bytes_en_o = crypt_q_i;
        advance        = (sub_bytes_out_req_i & crypt_q_i) | dec_key_gen_q_i;
        // No result released on a selector fault
        out_valid_o    = advance & ~sel_err_i;
        if (out_valid_o && out_ready_i) begin
          sub_bytes_out_ack_o = crypt_q_i;
          state_we_o          = 1'b1;
          done_o              = 1'b1;
          state_d             = CTRL_IDLE;
        end
      end

      CTRL_CLEAR_S: begin
        phase_o     = PHASE_CLEAR;
        state_sel_o = STATE_CLEAR;
        state_we_o  = 1'b1;
        state_d     = CTRL_CLEAR_KD;
      end

      CTRL_CLEAR_KD: begin
        phase_o     = PHASE_CLEAR;
        out_valid_o = ~sel_err_i;
        if (key_clear_q_i) begin
          key_full_sel_o = KEY_FULL_CLEAR;
          key_dec_sel_o  = KEY_DEC_CLEAR;
        end
        // Cleared state goes straight to the output registers
        if (data_out_clear_q_i) begin
          add_rk_sel_o = ADD_RK_INIT;
        end
        // Writes only on the handshake so back-pressure holds everything
        if (out_valid_o && out_ready_i) begin
          key_full_we_o = key_clear_q_i;
          key_dec_we_o  = key_clear_q_i;
          done_o        = 1'b1;
          state_d       = CTRL_IDLE;
        end
      end

      CTRL_ERROR: begin
        alert_o = 1'b1;
      end

      // Invalid encoding, treat as a fault
      default: begin
        alert_o = 1'b1;
        state_d = CTRL_ERROR;
      end
    endcase

    // Faults override any transition
    if (sel_err_i || alert_fatal_i) begin
      state_d = CTRL_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hdl/cipher_ctrl_top.sv
// AES cipher control top; op_i and key_len_i must stay stable from acceptance until out_valid_o is taken
`timescale 1ns/1ns

module cipher_ctrl_top import aes_ctrl_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Command and result handshakes
  input  logic               in_valid_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  input  logic               out_ready_i,

  // Command fields
  input  ciph_op_e           op_i,
  input  key_len_e           key_len_i,
  input  logic               crypt_i,
  input  logic               dec_key_gen_i,
  input  logic               key_clear_i,
  input  logic               data_out_clear_i,

  // Faults and alert
  input  logic               sel_err_i,
  input  logic               alert_fatal_i,
  output logic               alert_o,

  // Cipher datapath
  output state_sel_e         state_sel_o,
  output logic               state_we_o,
  output logic               sub_bytes_en_o,
  input  logic               sub_bytes_out_req_i,
  output logic               sub_bytes_out_ack_o,
  output add_rk_sel_e        add_rk_sel_o,

  // Key expand datapath
  output key_full_sel_e      key_full_sel_o,
  output logic               key_full_we_o,
  output key_dec_sel_e       key_dec_sel_o,
  output logic               key_dec_we_o,
  output logic               key_expand_en_o,
  input  logic               key_expand_out_req_i,
  output logic               key_expand_out_ack_o,
  output logic               key_expand_clear_o,
  output logic [RndCtrW-1:0] rnd_ctr_o,
  output key_words_sel_e     key_words_sel_o,
  output round_key_sel_e     round_key_sel_o
);

  // Sequencing between FSM and helpers
  logic          start, done, round_adv, last_round;
  ctrl_phase_e   phase;
  key_full_sel_e key_full_init;

  // Command flags, next and held
  logic crypt_d, dec_key_gen_d, key_clear_d, data_out_clear_d;
  logic crypt_q, dec_key_gen_q, key_clear_q, data_out_clear_q;

  // Same-named ports connect to the top ports
  cipher_ctrl_fsm u_fsm (
    .start_o            (start),
    .done_o             (done),
    .last_round_i       (last_round),
    .round_adv_o        (round_adv),
    .phase_o            (phase),
    .key_full_init_i    (key_full_init),
    .crypt_d_o          (crypt_d),
    .dec_key_gen_d_o    (dec_key_gen_d),
    .key_clear_d_o      (key_clear_d),
    .data_out_clear_d_o (data_out_clear_d),
    .crypt_q_i          (crypt_q),
    .dec_key_gen_q_i    (dec_key_gen_q),
    .key_clear_q_i      (key_clear_q),
    .data_out_clear_q_i (data_out_clear_q),
    .*
  );

  cipher_round_ctr u_round_ctr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .key_len_i    (key_len_i),
    .round_adv_i  (round_adv),
    .rnd_ctr_o    (rnd_ctr_o),
    .last_round_o (last_round)
  );

  cipher_key_sel u_key_sel (
    .phase_i          (phase),
    .op_i             (op_i),
    .key_len_i        (key_len_i),
    .dec_key_gen_q_i  (dec_key_gen_q),
    .key_full_init_o  (key_full_init),
    .key_words_sel_o  (key_words_sel_o),
    .round_key_sel_o  (round_key_sel_o)
  );

  cipher_cmd_regs u_cmd_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .start_i            (start),
    .done_i             (done),
    .crypt_d_i          (crypt_d),
    .dec_key_gen_d_i    (dec_key_gen_d),
    .key_clear_d_i      (key_clear_d),
    .data_out_clear_d_i (data_out_clear_d),
    .crypt_q_o          (crypt_q),
    .dec_key_gen_q_o    (dec_key_gen_q),
    .key_clear_q_o      (key_clear_q),
    .data_out_clear_q_o (data_out_clear_q)
  );

endmodule

// File: hdl/cipher_key_sel.sv
// Key selector decode, purely combinational; inputs must be stable for the whole operation
`timescale 1ns/1ns

module cipher_key_sel import aes_ctrl_pkg::*; (
  input  ctrl_phase_e    phase_i,
  input  ciph_op_e       op_i,
  input  key_len_e       key_len_i,
  input  logic           dec_key_gen_q_i,
  output key_full_sel_e  key_full_init_o,
  output key_words_sel_e key_words_sel_o,
  output round_key_sel_e round_key_sel_o
);

  logic           inv_op;
  key_words_sel_e upper_words;

  assign inv_op = (op_i == CIPH_INV);

  // Decryption starts from the last round key
  assign key_full_init_o = inv_op ? KEY_FULL_DEC_INIT : KEY_FULL_ENC_INIT;

  // Upper half of the wide key
  assign upper_words = (key_len_i == AES_192) ? KEY_WORDS_2345 : KEY_WORDS_4567;

  always_comb begin
    key_words_sel_o = KEY_WORDS_ZERO;
    if (!dec_key_gen_q_i) begin
      unique case (phase_i)
        PHASE_INIT: begin
          if (key_len_i == AES_128) begin
            key_words_sel_o = KEY_WORDS_0123;
          end else begin
            key_words_sel_o = inv_op ? upper_words : KEY_WORDS_0123;
          end
        end
        PHASE_ROUND, PHASE_FINISH: begin
          if (key_len_i == AES_128) begin
            key_words_sel_o = KEY_WORDS_0123;
          end else begin
            key_words_sel_o = inv_op ? KEY_WORDS_0123 : upper_words;
          end
        end
        // Clear and idle add nothing
        default: key_words_sel_o = KEY_WORDS_ZERO;
      endcase
    end
  end

  // Equivalent inverse cipher needs mixed keys in regular rounds
  assign round_key_sel_o = (inv_op && phase_i == PHASE_ROUND) ? ROUND_KEY_MIXED
                                                               : ROUND_KEY_DIRECT;

endmodule

// File: hdl/cipher_round_ctr.sv
// Round counter; key_len_i is sampled on start only, invalid lengths count as AES-256
`timescale 1ns/1ns

module cipher_round_ctr import aes_ctrl_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  key_len_e           key_len_i,
  input  logic               round_adv_i,
  output logic [RndCtrW-1:0] rnd_ctr_o,
  output logic               last_round_o
);

  logic [RndCtrW-1:0] rnd_ctr_q, num_rounds_d, num_rounds_q;

  // Nr from key length
  always_comb begin
    unique case (key_len_i)
      AES_128: num_rounds_d = NumRounds128;
      AES_192: num_rounds_d = NumRounds192;
      default: num_rounds_d = NumRounds256;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= '0;
    end else if (start_i) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= num_rounds_d;
    end else if (round_adv_i) begin
      rnd_ctr_q <= rnd_ctr_q + RndCtrW'(1);
    end
  end

  // Last regular round, final round follows
  assign last_round_o = (num_rounds_q != '0) && (rnd_ctr_q >= num_rounds_q - RndCtrW'(1));
  assign rnd_ctr_o    = rnd_ctr_q;

endmodule

// File: verif/cipher_ctrl_props.sv
// Handshake and alert properties for the control FSM, sampled on clk_i and idle during reset
`timescale 1ns/1ns

module cipher_ctrl_props import aes_ctrl_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        in_ready_i,
  input logic        out_valid_i,
  input logic        out_ready_i,
  input logic        alert_i,
  input logic        sel_err_i,
  input logic        alert_fatal_i,
  input ctrl_state_e state_i
);

  // Result stays offered until taken, faults may withdraw it
  out_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || sel_err_i || alert_fatal_i)
    out_valid_i && !out_ready_i |=> out_valid_i)
    else $error("out_valid_o dropped before out_ready_i");

  // Terminal error, alert sticks until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_i |=> alert_i)
    else $error("alert_o fell without reset");

  in_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_i |-> state_i == CTRL_IDLE)
    else $error("in_ready_o high outside idle");

endmodule

// File: include/tb_cipher_ctrl_tasks.svh
// Testbench tasks, included inside tb_cipher_ctrl and relying on its signal names and TimeoutCycles
`ifndef TB_CIPHER_CTRL_TASKS_SVH
`define TB_CIPHER_CTRL_TASKS_SVH

//////////////////////////////////////////////////
// Failure reporting and checks
//////////////////////////////////////////////////

task automatic stop_on_error();
  $display("STATUS: FAIL");
  $fatal(1, "stopping at first error");
endtask

// Any failure that is not a value mismatch
task automatic report_failure(input string what);
  $display("ERROR at %0t ns: %s", $time, what);
  stop_on_error();
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    stop_on_error();
  end
endtask

//////////////////////////////////////////////////
// Reset and bounded waits
//////////////////////////////////////////////////

// Reset held for 4 clock cycles, released on a falling edge
task automatic apply_reset();
  rst_ni = 1'b0;
  repeat (4) @(negedge clk_i);
  rst_ni = 1'b1;
endtask

// Returns on the rising edge where out_valid_o is seen
// Outputs still show the values from before that edge
task automatic wait_out_valid();
  int cycles;
  cycles = 0;
  @(posedge clk_i);
  while (!out_valid_o) begin
    if (cycles == TimeoutCycles) begin
      report_failure("timeout while waiting for out_valid_o");
    end else begin
      cycles++;
      @(posedge clk_i);
    end
  end
endtask

//////////////////////////////////////////////////
// Datapath responder
//////////////////////////////////////////////////

// One req line, raised 0 to 3 cycles after enable, dropped after the ack
task automatic update_req(input logic en, input logic acked, inout logic req, inout int delay);
  if (req && acked) begin
    req   = 1'b0;
    delay = -1;
  end else if (!req && en) begin
    if (delay < 0) begin
      delay = $urandom_range(3, 0);
    end
    if (delay == 0) begin
      req   = 1'b1;
      delay = -1;
    end else begin
      delay = delay - 1;
    end
  end
endtask

// Called on every falling edge
task automatic step_responder();
  if (!rst_ni) begin
    sub_bytes_out_req_i  = 1'b0;
    key_expand_out_req_i = 1'b0;
    sb_delay             = -1;
    ke_delay             = -1;
  end else begin
    update_req(sub_bytes_en_o, sb_acked, sub_bytes_out_req_i, sb_delay);
    update_req(key_expand_en_o, ke_acked, key_expand_out_req_i, ke_delay);
  end
endtask

`endif

// File: verif/tb_cipher_ctrl.sv
// Directed testbench for the AES control unit; datapath req latency is random from a fixed seed
`timescale 1ns/1ns

module tb_cipher_ctrl import aes_ctrl_pkg::*; ();

  localparam int TimeoutCycles = 200;
  localparam int Seed          = 73855;

  logic               clk_i, rst_ni;
  logic               in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  ciph_op_e           op_i;
  key_len_e           key_len_i;
  logic               crypt_i, dec_key_gen_i, key_clear_i, data_out_clear_i;
  logic               sel_err_i, alert_fatal_i, alert_o;
  state_sel_e         state_sel_o;
  logic               state_we_o, sub_bytes_en_o, sub_bytes_out_ack_o;
  logic               sub_bytes_out_req_i = 1'b0;
  add_rk_sel_e        add_rk_sel_o;
  key_full_sel_e      key_full_sel_o;
  key_dec_sel_e       key_dec_sel_o;
  logic               key_full_we_o, key_dec_we_o, key_expand_en_o;
  logic               key_expand_out_ack_o, key_expand_clear_o;
  logic               key_expand_out_req_i = 1'b0;
  logic [RndCtrW-1:0] rnd_ctr_o;
  key_words_sel_e     key_words_sel_o;
  round_key_sel_e     round_key_sel_o;

  // Responder state, acks sampled at the rising edge
  int   sb_delay = -1;
  int   ke_delay = -1;
  int   ke_ack_total = 0;
  logic sb_acked = 1'b0;
  logic ke_acked = 1'b0;

  `include "tb_cipher_ctrl_tasks.svh"

  cipher_ctrl_top DUT (.*);

  bind cipher_ctrl_fsm cipher_ctrl_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_ready_i    (in_ready_o),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .alert_i       (alert_o),
    .sel_err_i     (sel_err_i),
    .alert_fatal_i (alert_fatal_i),
    .state_i       (state_q)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    sb_acked <= sub_bytes_out_ack_o;
    ke_acked <= key_expand_out_ack_o;
    if (key_expand_out_ack_o) begin
      ke_ack_total <= ke_ack_total + 1;
    end
  end

  always @(negedge clk_i) step_responder();

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  // Returns on the falling edge one edge after acceptance
  task automatic send_cmd(input ciph_op_e op, input key_len_e kl, input logic crypt,
                          input logic dkg, input logic kc, input logic doc);
    int cycles;
    cycles = 0;
    while (!in_ready_o) begin
      if (cycles == TimeoutCycles) begin
        report_failure("timeout while waiting for in_ready_o");
      end else begin
        cycles++;
        @(negedge clk_i);
      end
    end
    in_valid_i       = 1'b1;
    op_i             = op;
    key_len_i        = kl;
    crypt_i          = crypt;
    dec_key_gen_i    = dkg;
    key_clear_i      = kc;
    data_out_clear_i = doc;
    @(posedge clk_i);
    // Key expand is cleared on acceptance of a crypt or key generation only
    check_value("key_expand_clear_o", 32'(key_expand_clear_o), 32'(crypt | dkg));
    @(negedge clk_i);
    // op_i and key_len_i stay put until the result is taken
    in_valid_i       = 1'b0;
    crypt_i          = 1'b0;
    dec_key_gen_i    = 1'b0;
    key_clear_i      = 1'b0;
    data_out_clear_i = 1'b0;
  endtask

  task automatic test_reset_values();
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    check_value("alert_o", 32'(alert_o), 32'd0);
    check_value("state_we_o", 32'(state_we_o), 32'd0);
    check_value("key_full_we_o", 32'(key_full_we_o), 32'd0);
    check_value("key_dec_we_o", 32'(key_dec_we_o), 32'd0);
    check_value("sub_bytes_out_ack_o", 32'(sub_bytes_out_ack_o), 32'd0);
    check_value("key_expand_out_ack_o", 32'(key_expand_out_ack_o), 32'd0);
    check_value("rnd_ctr_o", 32'(rnd_ctr_o), 32'd0);
  endtask

  task automatic test_encrypt(input key_len_e kl, input int nr, input int exp_acks);
    int base;
    base = ke_ack_total;
    send_cmd(CIPH_FWD, kl, 1'b1, 1'b0, 1'b0, 1'b0);
    wait_out_valid();
    check_value("rnd_ctr_o", 32'(rnd_ctr_o), 32'(nr));
    // out_ready_i high, result taken on this edge
    @(negedge clk_i);
    check_value("key_expand_out_ack_o pulses", 32'(ke_ack_total - base), 32'(exp_acks));
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
  endtask

  task automatic test_decrypt_selectors();
    int cycles;
    int mixed_seen;
    cycles     = 0;
    mixed_seen = 0;
    send_cmd(CIPH_INV, AES_192, 1'b1, 1'b0, 1'b0, 1'b0);
    // Init phase holds at least until the first key expand req
    check_value("key_words_sel_o", 32'(key_words_sel_o), 32'(KEY_WORDS_2345));
    check_value("round_key_sel_o", 32'(round_key_sel_o), 32'(ROUND_KEY_DIRECT));
    check_value("add_rk_sel_o", 32'(add_rk_sel_o), 32'(ADD_RK_INIT));
    check_value("key_expand_en_o", 32'(key_expand_en_o), 32'd1);
    check_value("sub_bytes_en_o", 32'(sub_bytes_en_o), 32'd0);
    @(posedge clk_i);
    while (!out_valid_o) begin
      if (cycles == TimeoutCycles) begin
        report_failure("timeout while waiting for out_valid_o in decryption");
      end else begin
        if (sub_bytes_en_o && key_expand_en_o) begin
          check_value("round_key_sel_o", 32'(round_key_sel_o), 32'(ROUND_KEY_MIXED));
          check_value("add_rk_sel_o", 32'(add_rk_sel_o), 32'(ADD_RK_ROUND));
          mixed_seen++;
        end
        cycles++;
        @(posedge clk_i);
      end
    end
    check_value("regular round cycles seen", 32'(mixed_seen != 0), 32'd1);
    check_value("rnd_ctr_o", 32'(rnd_ctr_o), 32'd12);
    // Final round runs SubBytes without key expansion
    check_value("add_rk_sel_o", 32'(add_rk_sel_o), 32'(ADD_RK_FINAL));
    check_value("sub_bytes_en_o", 32'(sub_bytes_en_o), 32'd1);
    check_value("key_expand_en_o", 32'(key_expand_en_o), 32'd0);
    @(negedge clk_i);
  endtask

  task automatic test_back_pressure();
    int hold;
    hold        = $urandom_range(8, 2);
    out_ready_i = 1'b0;
    send_cmd(CIPH_FWD, AES_128, 1'b1, 1'b0, 1'b0, 1'b0);
    wait_out_valid();
    @(negedge clk_i);
    repeat (hold) begin
      check_value("out_valid_o", 32'(out_valid_o), 32'd1);
      check_value("state_we_o", 32'(state_we_o), 32'd0);
      check_value("key_full_we_o", 32'(key_full_we_o), 32'd0);
      check_value("key_dec_we_o", 32'(key_dec_we_o), 32'd0);
      @(negedge clk_i);
    end
    out_ready_i = 1'b1;
    @(negedge clk_i);
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
  endtask

  task automatic test_clears();
    send_cmd(CIPH_FWD, AES_128, 1'b0, 1'b0, 1'b1, 1'b1);
    // State wipe first
    check_value("state_we_o", 32'(state_we_o), 32'd1);
    check_value("state_sel_o", 32'(state_sel_o), 32'(STATE_CLEAR));
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    @(negedge clk_i);
    check_value("out_valid_o", 32'(out_valid_o), 32'd1);
    check_value("key_full_we_o", 32'(key_full_we_o), 32'd1);
    check_value("key_full_sel_o", 32'(key_full_sel_o), 32'(KEY_FULL_CLEAR));
    check_value("key_dec_we_o", 32'(key_dec_we_o), 32'd1);
    check_value("key_dec_sel_o", 32'(key_dec_sel_o), 32'(KEY_DEC_CLEAR));
    @(negedge clk_i);
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
    // Key-only clear is one edge shorter
    send_cmd(CIPH_FWD, AES_128, 1'b0, 1'b0, 1'b1, 1'b0);
    check_value("out_valid_o", 32'(out_valid_o), 32'd1);
    check_value("state_we_o", 32'(state_we_o), 32'd0);
    check_value("key_full_we_o", 32'(key_full_we_o), 32'd1);
    @(negedge clk_i);
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
  endtask

  task automatic test_invalid_command();
    int hold;
    hold = $urandom_range(8, 3);
    send_cmd(CIPH_FWD, AES_128, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (hold) begin
      check_value("alert_o", 32'(alert_o), 32'd1);
      check_value("in_ready_o", 32'(in_ready_o), 32'd0);
      @(negedge clk_i);
    end
    // Only reset leaves the error state
    apply_reset();
    test_reset_values();
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni           = 1'b0;
    in_valid_i       = 1'b0;
    out_ready_i      = 1'b1;
    op_i             = CIPH_FWD;
    key_len_i        = AES_128;
    crypt_i          = 1'b0;
    dec_key_gen_i    = 1'b0;
    key_clear_i      = 1'b0;
    data_out_clear_i = 1'b0;
    sel_err_i        = 1'b0;
    alert_fatal_i    = 1'b0;
    apply_reset();
    test_reset_values();
    // AES-256 skips the key expand wait in init
    test_encrypt(AES_128, 10, 10);
    test_encrypt(AES_192, 12, 12);
    test_encrypt(AES_256, 14, 13);
    test_decrypt_selectors();
    test_back_pressure();
    test_clears();
    test_invalid_command();
    $display("STATUS: PASS");
    $finish;
  end

  // Overall limit on simulated time
  initial begin
    #2000000;
    report_failure("overall simulation time limit reached");
  end

endmodule

// File: verilog.f
+incdir+include
hdl/aes_ctrl_pkg.sv
hdl/cipher_cmd_regs.sv
hdl/cipher_round_ctr.sv
hdl/cipher_key_sel.sv
hdl/cipher_ctrl_fsm.sv
hdl/cipher_ctrl_top.sv
verif/cipher_ctrl_props.sv
verif/tb_cipher_ctrl.sv
